//--- up_pkg.sv
package up_pkg;

   localparam int         DATA_W    = 8;
   localparam int         MEM_DEPTH = 256;
   localparam logic [7:0] PC_RESET  = 8'h08;   // Nibble 8 is byte 4, high half

   // Datapath function select, also drives the address bus
   typedef enum logic [4:0] {
      ALU_ADD     = 5'd0,
      ALU_SUB     = 5'd1,
      ALU_MUL     = 5'd2,
      ALU_NAND    = 5'd3,
      ALU_XOR01   = 5'd4,
      ALU_XOR12   = 5'd5,
      ALU_XOR23   = 5'd6,
      ALU_CONST0  = 5'd16,
      ALU_CONST1  = 5'd17,
      ALU_CONST2  = 5'd18,
      ALU_CONST3  = 5'd19,
      ALU_PC_HALF = 5'd20,
      ALU_PC_INC  = 5'd21
   } alu_op_t;

   // Bit 2 picks the source, bits 1:0 the register
   typedef enum logic [2:0] {
      SEL_I0 = 3'd0,
      SEL_I1 = 3'd1,
      SEL_I2 = 3'd2,
      SEL_I3 = 3'd3,
      SEL_O0 = 3'd4,
      SEL_O1 = 3'd5,
      SEL_O2 = 3'd6,
      SEL_O3 = 3'd7
   } rb_sel_t;

   typedef enum logic [3:0] {
      OP_NOP  = 4'h0,
      OP_ADD  = 4'h1,
      OP_SUB  = 4'h2,
      OP_MUL  = 4'h3,
      OP_NAND = 4'h4,
      OP_XA   = 4'h5,
      OP_XB   = 4'h6,
      OP_XC   = 4'h7,
      OP_LDA0 = 4'h8,
      OP_LDA1 = 4'h9,
      OP_LDA2 = 4'hA,
      OP_LDA3 = 4'hB,
      OP_BEQ  = 4'hC,
      OP_OUT  = 4'hD,
      OP_HALT = 4'hE,
      OP_RSVD = 4'hF
   } opcode_t;

   typedef struct packed {
      alu_op_t op;
      logic    ir_we;
      logic    pc_we;
      rb_sel_t rb_sel;
      logic    rb_we;
   } ctrl_t;

endpackage

//--- up_datapath.sv
module up_datapath import up_pkg::*; (
   input  logic              clk,
   input  logic              nRst,
   input  logic [DATA_W-1:0] data_in,
   input  ctrl_t             ctrl,
   output logic [DATA_W-1:0] data_out,
   output logic [3:0]        ir,
   output logic              z
);

   logic [DATA_W-1:0] r [4];
   logic [DATA_W-1:0] pc;
   logic [DATA_W-1:0] wr_val;

   assign z = (r[1] == r[2]);

   always_comb begin
      case (ctrl.op)
         ALU_ADD:     data_out = r[1] + r[2];
         ALU_SUB:     data_out = r[1] - r[2];
         ALU_MUL:     data_out = r[1] * r[2];   // Low byte only
         ALU_NAND:    data_out = ~(r[1] & r[2]);
         ALU_XOR01:   data_out = r[0] ^ r[1];
         ALU_XOR12:   data_out = r[1] ^ r[2];
         ALU_XOR23:   data_out = r[2] ^ r[3];
         ALU_CONST0:  data_out = 8'h00;
         ALU_CONST1:  data_out = 8'h01;
         ALU_CONST2:  data_out = 8'h02;
         ALU_CONST3:  data_out = 8'h03;
         ALU_PC_HALF: data_out = pc >> 1;      // Byte holding the current nibble
         ALU_PC_INC:  data_out = pc + 1'b1;
         default:     data_out = data_in;
      endcase
   end

   // Register file source follows the top select bit
   assign wr_val = ctrl.rb_sel[2] ? data_out : data_in;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc <= PC_RESET;
         ir <= 4'h0;
         for (int i = 0; i < 4; i++) begin
            r[i] <= '0;
         end
      end else begin
         if (ctrl.ir_we) begin
            ir <= pc[0] ? data_in[3:0] : data_in[7:4];   // Even pc takes high nibble
         end
         if (ctrl.pc_we) begin
            pc <= data_out;
         end
         if (ctrl.rb_we) begin
            r[ctrl.rb_sel[1:0]] <= wr_val;
         end
      end
   end

   // Fetch and advance are separate sequencer steps
   a_no_fetch_advance_overlap: assert property (
      @(posedge clk) disable iff (!nRst)
      !(ctrl.pc_we && ctrl.ir_we)
   );

endmodule

//--- up_control.sv
module up_control import up_pkg::*; (
   input  logic       clk,
   input  logic       nRst,
   input  logic       run,
   input  logic [3:0] ir,
   input  logic       z,
   output ctrl_t      ctrl,
   output logic       out_valid,
   output logic       halted
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_FETCH,
      S_ADVANCE,
      S_EXEC,
      S_HALTED
   } state_t;

   state_t  state;
   state_t  state_nxt;
   opcode_t opcode;

   assign opcode = opcode_t'(ir);

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= S_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         S_IDLE:    if (run) state_nxt = S_FETCH;
         S_FETCH:   state_nxt = S_ADVANCE;
         S_ADVANCE: state_nxt = S_EXEC;
         S_EXEC:    state_nxt = (opcode == OP_HALT) ? S_HALTED : S_FETCH;
         default:   state_nxt = S_HALTED;   // Only reset leaves here
      endcase
   end

   always_comb begin
      ctrl.op     = ALU_PC_HALF;   // Keeps the address bus off data_in
      ctrl.ir_we  = 1'b0;
      ctrl.pc_we  = 1'b0;
      ctrl.rb_sel = SEL_O1;
      ctrl.rb_we  = 1'b0;
      out_valid   = 1'b0;

      case (state)
         S_FETCH: begin
            ctrl.op    = ALU_PC_HALF;
            ctrl.ir_we = 1'b1;
         end
         S_ADVANCE: begin
            ctrl.op    = ALU_PC_INC;
            ctrl.pc_we = 1'b1;
         end
         S_EXEC: begin
            case (opcode)
               OP_ADD: begin
                  ctrl.op    = ALU_ADD;
                  ctrl.rb_we = 1'b1;
               end
               OP_SUB: begin
                  ctrl.op    = ALU_SUB;
                  ctrl.rb_we = 1'b1;
               end
               OP_MUL: begin
                  ctrl.op    = ALU_MUL;
                  ctrl.rb_we = 1'b1;
               end
               OP_NAND: begin
                  ctrl.op    = ALU_NAND;
                  ctrl.rb_we = 1'b1;
               end
               OP_XA: begin
                  ctrl.op    = ALU_XOR01;
                  ctrl.rb_we = 1'b1;
               end
               OP_XB: begin
                  ctrl.op    = ALU_XOR12;
                  ctrl.rb_we = 1'b1;
               end
               OP_XC: begin
                  ctrl.op    = ALU_XOR23;
                  ctrl.rb_we = 1'b1;
               end
               OP_LDA0, OP_LDA1, OP_LDA2, OP_LDA3: begin
                  ctrl.op     = alu_op_t'({3'b100, ir[1:0]});   // CONSTn as address
                  ctrl.rb_sel = rb_sel_t'({1'b0, ir[1:0]});     // rn from memory
                  ctrl.rb_we  = 1'b1;
               end
               OP_BEQ: begin
                  ctrl.op    = ALU_PC_INC;
                  ctrl.pc_we = z;   // Skip next nibble
               end
               OP_OUT: begin
                  ctrl.op   = ALU_ADD;   // r1+r2 on the bus, no write
                  out_valid = 1'b1;
               end
               default: ;   // NOP, HALT, reserved
            endcase
         end
         default: ;
      endcase
   end

   assign halted = (state == S_HALTED);

   a_halted_quiet: assert property (
      @(posedge clk) disable iff (!nRst)
      halted |-> !(ctrl.ir_we || ctrl.pc_we || ctrl.rb_we || out_valid)
   );

endmodule

//--- up_memory.sv
module up_memory import up_pkg::*; (
   input  logic              clk,
   input  logic [7:0]        addr,
   input  logic              prog_we,
   input  logic [7:0]        prog_addr,
   input  logic [DATA_W-1:0] prog_data,
   output logic [DATA_W-1:0] rdata
);

   logic [DATA_W-1:0] mem [MEM_DEPTH];

   // Datapath sees the byte in the same cycle
   assign rdata = mem[addr];

   always_ff @(posedge clk) begin
      if (prog_we) begin
         mem[prog_addr] <= prog_data;
      end
   end

   a_prog_addr_known: assert property (
      @(posedge clk)
      prog_we |-> !$isunknown(prog_addr)
   );

endmodule

//--- up_top.sv
module up_top import up_pkg::*; (
   input  logic              clk,
   input  logic              nRst,
   input  logic              run,
   input  logic              prog_we,
   input  logic [7:0]        prog_addr,
   input  logic [DATA_W-1:0] prog_data,
   output logic              out_valid,
   output logic [DATA_W-1:0] out_data,
   output logic              halted
);

   ctrl_t             ctrl;
   logic [DATA_W-1:0] data_out;
   logic [DATA_W-1:0] rdata;
   logic [3:0]        ir;
   logic              z;

   assign out_data = data_out;   // Also the memory address

   up_datapath i_datapath (
      .clk      (clk),
      .nRst     (nRst),
      .data_in  (rdata),
      .ctrl     (ctrl),
      .data_out (data_out),
      .ir       (ir),
      .z        (z)
   );

   up_control i_control (
      .clk       (clk),
      .nRst      (nRst),
      .run       (run),
      .ir        (ir),
      .z         (z),
      .ctrl      (ctrl),
      .out_valid (out_valid),
      .halted    (halted)
   );

   up_memory i_memory (
      .clk       (clk),
      .addr      (data_out),
      .prog_we   (prog_we),
      .prog_addr (prog_addr),
      .prog_data (prog_data),
      .rdata     (rdata)
   );

endmodule

//--- tb_up_top.sv
module tb_up_top import up_pkg::*;;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RUN_TIMEOUT = 400;   // Cycles allowed until halted
   localparam int HALT_WINDOW = 20;

   logic       clk;
   logic       nRst;
   logic       run;
   logic       prog_we;
   logic [7:0] prog_addr;
   logic [7:0] prog_data;
   logic       out_valid;
   logic [7:0] out_data;
   logic       halted;

   logic [31:0] rng = 32'h8877;
   logic [7:0]  image [256];
   logic [3:0]  prog [$];
   logic [7:0]  exp_data [$];
   int          exp_cyc [$];
   int          exp_halt_cyc;
   int          cyc;
   bit          halt_seen;

   up_top i_dut (
      .clk       (clk),
      .nRst      (nRst),
      .run       (run),
      .prog_we   (prog_we),
      .prog_addr (prog_addr),
      .prog_data (prog_data),
      .out_valid (out_valid),
      .out_data  (out_data),
      .halted    (halted)
   );

   always #10 clk = ~clk;

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input int expected, input int actual);
      stop_on_error($sformatf("ERR %0t %s expected %0d got %0d", $time, name, expected, actual));
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Data bytes 0..3, then the program nibbles from byte 4, high half first
   task automatic build_image(input bit equal12, output int n_bytes);
      for (int a = 0; a < 4; a++) begin
         rng      = xorshift(rng);
         image[a] = rng[7:0];
      end
      if (equal12) begin
         image[2] = image[1];
      end else if (image[2] == image[1]) begin
         image[2] = image[1] + 8'd1;
      end
      n_bytes = 4 + (prog.size() + 1) / 2;
      for (int b = 4; b < n_bytes; b++) begin
         image[b] = 8'h00;   // Odd tail pads with NOP
      end
      for (int i = 0; i < prog.size(); i++) begin
         if (i % 2 == 0) begin
            image[4 + i / 2][7:4] = prog[i];
         end else begin
            image[4 + i / 2][3:0] = prog[i];
         end
      end
   endtask

   task automatic load_image(input int n_bytes);
      for (int a = 0; a < n_bytes; a++) begin
         @(negedge clk);
         prog_we   = 1'b1;
         prog_addr = a[7:0];
         prog_data = image[a];
      end
      @(negedge clk);
      prog_we = 1'b0;
   endtask

   // ISA model, instruction k executes in cycle 3k+3 after run is sampled
   task automatic predict_outputs();
      logic [7:0] pc;
      logic [7:0] r [4];
      logic [7:0] sum;
      logic [3:0] nib;
      bit         done;
      pc   = PC_RESET;
      done = 1'b0;
      for (int i = 0; i < 4; i++) begin
         r[i] = 8'h00;
      end
      exp_data.delete();
      exp_cyc.delete();
      exp_halt_cyc = -1;
      for (int k = 0; k < 100 && !done; k++) begin
         nib = pc[0] ? image[pc[7:1]][3:0] : image[pc[7:1]][7:4];
         pc  = pc + 8'd1;
         case (nib)
            OP_ADD:  r[1] = r[1] + r[2];
            OP_SUB:  r[1] = r[1] - r[2];
            OP_MUL:  r[1] = r[1] * r[2];
            OP_NAND: r[1] = ~(r[1] & r[2]);
            OP_XA:   r[1] = r[0] ^ r[1];
            OP_XB:   r[1] = r[1] ^ r[2];
            OP_XC:   r[1] = r[2] ^ r[3];
            OP_LDA0, OP_LDA1, OP_LDA2, OP_LDA3: r[nib[1:0]] = image[nib[1:0]];
            OP_BEQ: begin
               if (r[1] == r[2]) begin
                  pc = pc + 8'd1;
               end
            end
            OP_OUT: begin
               sum = r[1] + r[2];
               exp_data.push_back(sum);
               exp_cyc.push_back(3 * k + 3);
            end
            OP_HALT: begin
               exp_halt_cyc = 3 * k + 4;
               done         = 1'b1;
            end
            default: ;
         endcase
      end
   endtask

   task automatic run_program(input bit equal12);
      int n_bytes;
      int i;
      @(negedge clk);
      nRst    = 1'b0;
      run     = 1'b0;
      prog_we = 1'b0;
      repeat (4) @(negedge clk);
      nRst = 1'b1;
      build_image(equal12, n_bytes);
      load_image(n_bytes);
      predict_outputs();
      @(negedge clk);
      run = 1'b1;
      i   = 0;
      while (!halted && i < RUN_TIMEOUT) begin
         @(negedge clk);
         i++;
      end
      if (!halted) begin
         stop_on_error("Timeout while waiting for halted to rise");
      end
      repeat (HALT_WINDOW) @(negedge clk);   // Pulses here fail the monitor
      if (exp_data.size() != 0) begin
         stop_on_error($sformatf("%0d expected output pulses never appeared", exp_data.size()));
      end
   endtask

   // Cycle count is 0 at the edge that samples run high
   always @(posedge clk) begin
      if (!run) begin
         cyc       = -1;
         halt_seen = 1'b0;
      end else begin
         cyc = cyc + 1;
      end
      if (out_valid) begin
         if (exp_data.size() == 0) begin
            stop_on_error("out_valid pulsed although the model expects no output");
         end else begin
            assert (cyc == exp_cyc[0])
               else report_mismatch("out_valid cycle", exp_cyc[0], cyc);
            assert (out_data == exp_data[0])
               else report_mismatch("out_data", exp_data[0], out_data);
            exp_data.delete(0);
            exp_cyc.delete(0);
         end
      end
      if (halted && !halt_seen) begin
         halt_seen = 1'b1;
         assert (cyc == exp_halt_cyc)
            else report_mismatch("halted rise cycle", exp_halt_cyc, cyc);
      end
   end

   a_idle_quiet: assert property (@(posedge clk) !run |-> !out_valid && !halted)
      else stop_on_error("out_valid or halted was high while the core was idle");

   a_halt_sticky: assert property (
      @(posedge clk) disable iff (!nRst)
      halted |=> halted && !out_valid
   ) else stop_on_error("Core left the halted state or emitted output after HALT");

   a_single_pulse: assert property (
      @(posedge clk) disable iff (!nRst)
      out_valid |=> !out_valid
   ) else stop_on_error("out_valid stayed high for more than one cycle");

   initial begin
      clk       = 1'b0;
      nRst      = 1'b0;
      run       = 1'b0;
      prog_we   = 1'b0;
      prog_addr = 8'h00;
      prog_data = 8'h00;

      // Loads and ALU ops, OUT first to pin the 3k+3 timing
      prog = '{OP_OUT, OP_LDA1, OP_LDA2, OP_OUT, OP_ADD, OP_OUT, OP_SUB, OP_OUT,
               OP_MUL, OP_OUT, OP_NAND, OP_OUT, OP_HALT};
      run_program(1'b0);

      prog = '{OP_LDA0, OP_LDA1, OP_LDA2, OP_LDA3, OP_XA, OP_OUT, OP_XB, OP_OUT,
               OP_XC, OP_OUT, OP_HALT};
      run_program(1'b0);

      // Same BEQ program, equal then unequal operands
      prog = '{OP_LDA1, OP_LDA2, OP_BEQ, OP_OUT, OP_OUT, OP_RSVD, OP_HALT};
      run_program(1'b1);
      run_program(1'b0);

      prog = '{OP_LDA1, OP_OUT, OP_HALT, OP_OUT, OP_ADD, OP_OUT, OP_HALT};
      run_program(1'b0);

      $display("TEST OK");
      $finish;
   end

endmodule

//--- all.f
up_pkg.sv
up_datapath.sv
up_control.sv
up_memory.sv
up_top.sv
tb_up_top.sv
